/* source/delay_calc_pkg.sv */
// Delay calculator shared definitions
package delay_calc_pkg;

  // Address and row geometry
  localparam int unsigned AddrWidth = 20;
  localparam int unsigned RowOffsetWidth = 10;
  localparam int unsigned RowWidth = AddrWidth - RowOffsetWidth;

  // Burst geometry
  localparam int unsigned MaxBurstLen = 8;
  localparam int unsigned BurstLenWidth = 4;
  localparam int unsigned BurstSizeWidth = 3;
  localparam int unsigned BeatIdxWidth = $clog2(MaxBurstLen);

  // Response banks
  localparam int unsigned WBankCapacity = 8;
  localparam int unsigned RBankCapacity = 8;
  localparam int unsigned WIidWidth = 3;
  localparam int unsigned RIidWidth = 3;

  // Rank delay counter
  localparam int unsigned DelayWidth = 6;

  // Compressed access cost ordered from cheapest to most expensive
  typedef enum logic [1:0] {
    COST_HIT       = 2'd0,
    COST_ACTIVATE  = 2'd1,
    COST_PRECHARGE = 2'd2
  } mem_cost_e;

  typedef struct packed {
    logic                open;
    logic [RowWidth-1:0] row;
  } row_state_t;

  typedef struct packed {
    logic [WIidWidth-1:0]      iid;
    logic [AddrWidth-1:0]      addr;
    logic [BurstLenWidth-1:0]  burst_len;
    logic [BurstSizeWidth-1:0] burst_size;
  } burst_req_t;

  // Write burst plus the data beats that came along with the address
  typedef struct packed {
    burst_req_t               req;
    logic [BurstLenWidth-1:0] data_cnt;
  } wburst_req_t;

  typedef struct packed {
    logic                valid;
    mem_cost_e           cost;
    logic [RowWidth-1:0] row;
  } beat_cand_t;

  // Address of beat idx in an incrementing burst
  function automatic logic [AddrWidth-1:0] beat_addr(logic [AddrWidth-1:0] base,
                                                     logic [BurstSizeWidth-1:0] size,
                                                     logic [BeatIdxWidth-1:0] idx);
    return base + (AddrWidth'(idx) << size);
  endfunction

  function automatic mem_cost_e classify_cost(logic [AddrWidth-1:0] addr, row_state_t state);
    if (!state.open) begin
      return COST_ACTIVATE;
    end
    if (addr[AddrWidth-1:RowOffsetWidth] == state.row) begin
      return COST_HIT;
    end
    return COST_PRECHARGE;
  endfunction

endpackage

/* source/write_slot_table.sv */
// Write burst slot table
module write_slot_table #(
  parameter int unsigned NumWSlots = 6
) (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  input  delay_calc_pkg::wburst_req_t              i_waddr,
  input  logic                                     i_waddr_valid,
  output logic                                     o_waddr_ready,
  input  logic                                     i_wdata_valid,
  output logic                                     o_wdata_ready,
  input  delay_calc_pkg::row_state_t               i_row_state,
  input  logic                                     i_issue,
  input  logic                                     i_done,
  output delay_calc_pkg::beat_cand_t               o_cand,
  output logic [delay_calc_pkg::WBankCapacity-1:0] o_release_en,
  input  logic [delay_calc_pkg::WBankCapacity-1:0] i_released_onehot
);
  import delay_calc_pkg::*;

  localparam int unsigned SlotIdxWidth = $clog2(NumWSlots);

  // Rank 0 is the oldest valid slot
  typedef struct packed {
    logic                      v;
    logic [SlotIdxWidth-1:0]   rank;
    logic [WIidWidth-1:0]      iid;
    logic [AddrWidth-1:0]      addr;
    logic [BurstSizeWidth-1:0] size;
    logic [MaxBurstLen-1:0]    data;
    logic [MaxBurstLen-1:0]    pend;
    logic [MaxBurstLen-1:0]    done;
  } w_slot_t;

  w_slot_t slot_q[NumWSlots];
  w_slot_t slot_d[NumWSlots];
  logic [WBankCapacity-1:0] release_q;
  logic [WBankCapacity-1:0] release_d;

  logic [NumWSlots-1:0] retire;
  logic [BeatIdxWidth-1:0] beat_idx[NumWSlots];
  logic [NumWSlots-1:0] beat_ok;
  mem_cost_e beat_cost[NumWSlots];
  logic [RowWidth-1:0] beat_row[NumWSlots];

  logic free_found;
  logic [SlotIdxWidth-1:0] free_idx;
  logic fill_found;
  logic [SlotIdxWidth-1:0] fill_idx;
  logic sel_found;
  logic [SlotIdxWidth-1:0] sel_idx;

  // Per slot candidate beat with beats that finish on this done pulse counted as done
  always_comb begin
    logic [MaxBurstLen-1:0] open_beats;
    logic [AddrWidth-1:0] addr;
    for (int s = 0; s < NumWSlots; s++) begin
      retire[s] = slot_q[s].v && &slot_q[s].done;
      open_beats = ~(slot_q[s].done | (slot_q[s].pend & {MaxBurstLen{i_done}}));
      beat_idx[s] = '0;
      for (int b = MaxBurstLen - 1; b >= 0; b--) begin
        if (open_beats[b]) begin
          beat_idx[s] = BeatIdxWidth'(b);
        end
      end
      beat_ok[s] = slot_q[s].v && |open_beats && slot_q[s].data[beat_idx[s]] &&
                   !slot_q[s].pend[beat_idx[s]];
      addr = beat_addr(slot_q[s].addr, slot_q[s].size, beat_idx[s]);
      beat_cost[s] = classify_cost(addr, i_row_state);
      beat_row[s] = addr[AddrWidth-1:RowOffsetWidth];
    end
  end

  // Free slot, oldest slot waiting for data, and cheapest then oldest candidate
  always_comb begin
    free_found = 1'b0;
    free_idx = '0;
    fill_found = 1'b0;
    fill_idx = '0;
    sel_found = 1'b0;
    sel_idx = '0;
    for (int s = 0; s < NumWSlots; s++) begin
      if (!slot_q[s].v && !free_found) begin
        free_found = 1'b1;
        free_idx = SlotIdxWidth'(s);
      end
      if (slot_q[s].v && !(&slot_q[s].data) &&
          (!fill_found || slot_q[s].rank < slot_q[fill_idx].rank)) begin
        fill_found = 1'b1;
        fill_idx = SlotIdxWidth'(s);
      end
      if (beat_ok[s] && (!sel_found || beat_cost[s] < beat_cost[sel_idx] ||
          (beat_cost[s] == beat_cost[sel_idx] && slot_q[s].rank < slot_q[sel_idx].rank))) begin
        sel_found = 1'b1;
        sel_idx = SlotIdxWidth'(s);
      end
    end
  end

  assign o_waddr_ready = free_found;
  assign o_wdata_ready = fill_found;
  assign o_cand = '{valid: sel_found, cost: beat_cost[sel_idx], row: beat_row[sel_idx]};
  assign o_release_en = release_q;

  always_comb begin
    logic [SlotIdxWidth-1:0] live;
    logic [SlotIdxWidth-1:0] dec;
    live = '0;
    for (int s = 0; s < NumWSlots; s++) begin
      live = live + SlotIdxWidth'(slot_q[s].v && !retire[s]);
    end
    release_d = release_q & ~i_released_onehot;
    for (int s = 0; s < NumWSlots; s++) begin
      slot_d[s] = slot_q[s];
      // Close the rank gap left by older slots that retire now
      dec = '0;
      for (int j = 0; j < NumWSlots; j++) begin
        dec = dec + SlotIdxWidth'(retire[j] && slot_q[j].rank < slot_q[s].rank);
      end
      slot_d[s].rank = slot_q[s].rank - dec;
      if (retire[s]) begin
        slot_d[s].v = 1'b0;
        release_d[slot_q[s].iid] = 1'b1;
      end
      if (i_done) begin
        slot_d[s].done = slot_q[s].done | slot_q[s].pend;
        slot_d[s].pend = '0;
      end
      if (i_issue && sel_idx == SlotIdxWidth'(s)) begin
        slot_d[s].pend[beat_idx[s]] = 1'b1;
      end
      // Data arrives in beat order, so the lowest clear bit is the next one
      if (i_wdata_valid && fill_found && fill_idx == SlotIdxWidth'(s)) begin
        slot_d[s].data = slot_q[s].data | (slot_q[s].data + 1'b1);
      end
      if (i_waddr_valid && free_found && free_idx == SlotIdxWidth'(s)) begin
        slot_d[s].v = 1'b1;
        slot_d[s].rank = live;
        slot_d[s].iid = i_waddr.req.iid;
        slot_d[s].addr = i_waddr.req.addr;
        slot_d[s].size = i_waddr.req.burst_size;
        slot_d[s].pend = '0;
        for (int b = 0; b < MaxBurstLen; b++) begin
          slot_d[s].done[b] = b >= i_waddr.req.burst_len;
          slot_d[s].data[b] = (b >= i_waddr.req.burst_len) || (b < i_waddr.data_cnt);
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      slot_q <= '{default: '0};
      release_q <= '0;
    end else begin
      slot_q <= slot_d;
      release_q <= release_d;
    end
  end

  // The scheduler only issues what this table offers
  assert property (@(posedge clk_i) disable iff (!rst_ni) i_issue |-> o_cand.valid);

  // The response bank only confirms releases that were enabled
  assert property (@(posedge clk_i) disable iff (!rst_ni)
                   (i_released_onehot & ~o_release_en) == '0);

endmodule

/* source/read_slot_table.sv */
// Read burst slot table
module read_slot_table #(
  parameter int unsigned NumRSlots = 6
) (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  input  delay_calc_pkg::burst_req_t               i_raddr,
  input  logic                                     i_raddr_valid,
  output logic                                     o_raddr_ready,
  input  delay_calc_pkg::row_state_t               i_row_state,
  input  logic                                     i_issue,
  input  logic                                     i_done,
  output delay_calc_pkg::beat_cand_t               o_cand,
  output logic [delay_calc_pkg::RBankCapacity-1:0] o_release_en,
  input  logic [delay_calc_pkg::RBankCapacity-1:0] i_released_onehot
);
  import delay_calc_pkg::*;

  localparam int unsigned SlotIdxWidth = $clog2(NumRSlots);

  // Read beats need no data flags
  typedef struct packed {
    logic                      v;
    logic [SlotIdxWidth-1:0]   rank;
    logic [RIidWidth-1:0]      iid;
    logic [AddrWidth-1:0]      addr;
    logic [BurstSizeWidth-1:0] size;
    logic [MaxBurstLen-1:0]    pend;
    logic [MaxBurstLen-1:0]    done;
  } r_slot_t;

  r_slot_t slot_q[NumRSlots];
  r_slot_t slot_d[NumRSlots];
  logic [RBankCapacity-1:0] release_q;
  logic [RBankCapacity-1:0] release_d;

  logic [NumRSlots-1:0] retire;
  logic [BeatIdxWidth-1:0] beat_idx[NumRSlots];
  logic [NumRSlots-1:0] beat_ok;
  mem_cost_e beat_cost[NumRSlots];
  logic [RowWidth-1:0] beat_row[NumRSlots];

  logic free_found;
  logic [SlotIdxWidth-1:0] free_idx;
  logic sel_found;
  logic [SlotIdxWidth-1:0] sel_idx;

  always_comb begin
    logic [MaxBurstLen-1:0] open_beats;
    logic [AddrWidth-1:0] addr;
    for (int s = 0; s < NumRSlots; s++) begin
      retire[s] = slot_q[s].v && &slot_q[s].done;
      open_beats = ~(slot_q[s].done | (slot_q[s].pend & {MaxBurstLen{i_done}}));
      beat_idx[s] = '0;
      for (int b = MaxBurstLen - 1; b >= 0; b--) begin
        if (open_beats[b]) begin
          beat_idx[s] = BeatIdxWidth'(b);
        end
      end
      beat_ok[s] = slot_q[s].v && |open_beats && !slot_q[s].pend[beat_idx[s]];
      addr = beat_addr(slot_q[s].addr, slot_q[s].size, beat_idx[s]);
      beat_cost[s] = classify_cost(addr, i_row_state);
      beat_row[s] = addr[AddrWidth-1:RowOffsetWidth];
    end
  end

  always_comb begin
    free_found = 1'b0;
    free_idx = '0;
    sel_found = 1'b0;
    sel_idx = '0;
    for (int s = 0; s < NumRSlots; s++) begin
      if (!slot_q[s].v && !free_found) begin
        free_found = 1'b1;
        free_idx = SlotIdxWidth'(s);
      end
      if (beat_ok[s] && (!sel_found || beat_cost[s] < beat_cost[sel_idx] ||
          (beat_cost[s] == beat_cost[sel_idx] && slot_q[s].rank < slot_q[sel_idx].rank))) begin
        sel_found = 1'b1;
        sel_idx = SlotIdxWidth'(s);
      end
    end
  end

  assign o_raddr_ready = free_found;
  assign o_cand = '{valid: sel_found, cost: beat_cost[sel_idx], row: beat_row[sel_idx]};
  assign o_release_en = release_q;

  always_comb begin
    logic [SlotIdxWidth-1:0] live;
    logic [SlotIdxWidth-1:0] dec;
    live = '0;
    for (int s = 0; s < NumRSlots; s++) begin
      live = live + SlotIdxWidth'(slot_q[s].v && !retire[s]);
    end
    release_d = release_q & ~i_released_onehot;
    for (int s = 0; s < NumRSlots; s++) begin
      slot_d[s] = slot_q[s];
      dec = '0;
      for (int j = 0; j < NumRSlots; j++) begin
        dec = dec + SlotIdxWidth'(retire[j] && slot_q[j].rank < slot_q[s].rank);
      end
      slot_d[s].rank = slot_q[s].rank - dec;
      if (retire[s]) begin
        slot_d[s].v = 1'b0;
        release_d[slot_q[s].iid] = 1'b1;
      end
      if (i_done) begin
        slot_d[s].done = slot_q[s].done | slot_q[s].pend;
        slot_d[s].pend = '0;
      end
      if (i_issue && sel_idx == SlotIdxWidth'(s)) begin
        slot_d[s].pend[beat_idx[s]] = 1'b1;
      end
      if (i_raddr_valid && free_found && free_idx == SlotIdxWidth'(s)) begin
        slot_d[s].v = 1'b1;
        slot_d[s].rank = live;
        slot_d[s].iid = i_raddr.iid;
        slot_d[s].addr = i_raddr.addr;
        slot_d[s].size = i_raddr.burst_size;
        slot_d[s].pend = '0;
        for (int b = 0; b < MaxBurstLen; b++) begin
          slot_d[s].done[b] = b >= i_raddr.burst_len;
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      slot_q <= '{default: '0};
      release_q <= '0;
    end else begin
      slot_q <= slot_d;
      release_q <= release_d;
    end
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni) i_issue |-> o_cand.valid);

  assert property (@(posedge clk_i) disable iff (!rst_ni)
                   (i_released_onehot & ~o_release_en) == '0);

endmodule

/* source/rank_scheduler.sv */
// Rank arbitration and delay counter
module rank_scheduler #(
  parameter int unsigned RowHitCost     = 4,
  parameter int unsigned ActivationCost = 6,
  parameter int unsigned PrechargeCost  = 5
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  delay_calc_pkg::beat_cand_t i_w_cand,
  input  delay_calc_pkg::beat_cand_t i_r_cand,
  output logic                       o_w_issue,
  output logic                       o_r_issue,
  output logic                       o_done,
  output delay_calc_pkg::row_state_t o_row_state
);
  import delay_calc_pkg::*;

  // Cycles spent on the rank for one beat of a given cost class
  function automatic logic [DelayWidth-1:0] expand_cost(mem_cost_e cost);
    case (cost)
      COST_HIT: begin
        return DelayWidth'(RowHitCost);
      end
      COST_ACTIVATE: begin
        return DelayWidth'(RowHitCost + ActivationCost);
      end
      default: begin
        return DelayWidth'(RowHitCost + ActivationCost + PrechargeCost);
      end
    endcase
  endfunction

  logic [DelayWidth-1:0] cnt_q;
  logic [DelayWidth-1:0] cnt_d;
  logic busy_q;
  logic busy_d;
  row_state_t row_q;
  row_state_t row_d;

  logic idle;
  beat_cand_t grant;

  // The last cycle of a beat is also the first cycle a new beat may issue
  assign idle = cnt_q == '0;
  assign o_w_issue = idle && i_w_cand.valid;
  assign o_r_issue = idle && !i_w_cand.valid && i_r_cand.valid;
  assign grant = i_w_cand.valid ? i_w_cand : i_r_cand;
  assign o_done = busy_q && idle;
  assign o_row_state = row_q;

  always_comb begin
    cnt_d = cnt_q;
    busy_d = busy_q;
    row_d = row_q;
    if (o_w_issue || o_r_issue) begin
      cnt_d = expand_cost(grant.cost) - DelayWidth'(1);
      busy_d = 1'b1;
      row_d = '{open: 1'b1, row: grant.row};
    end else if (!idle) begin
      cnt_d = cnt_q - DelayWidth'(1);
    end else begin
      busy_d = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
      busy_q <= 1'b0;
      row_q <= '0;
    end else begin
      cnt_q <= cnt_d;
      busy_q <= busy_d;
      row_q <= row_d;
    end
  end

  // A granted beat always carries one of the three cost classes
  assert property (@(posedge clk_i) disable iff (!rst_ni)
                   (o_w_issue || o_r_issue) |->
                   grant.cost inside {COST_HIT, COST_ACTIVATE, COST_PRECHARGE});

endmodule

/* source/delay_calculator_top.sv */
// Memory controller delay calculator
module delay_calculator_top #(
  parameter int unsigned NumWSlots      = 6,
  parameter int unsigned NumRSlots      = 6,
  parameter int unsigned RowHitCost     = 4,
  parameter int unsigned ActivationCost = 6,
  parameter int unsigned PrechargeCost  = 5
) (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  // Write address and data
  input  delay_calc_pkg::wburst_req_t              i_waddr,
  input  logic                                     i_waddr_valid,
  output logic                                     o_waddr_ready,
  input  logic                                     i_wdata_valid,
  output logic                                     o_wdata_ready,
  // Read address
  input  delay_calc_pkg::burst_req_t               i_raddr,
  input  logic                                     i_raddr_valid,
  output logic                                     o_raddr_ready,
  // Release enables and response bank feedback
  output logic [delay_calc_pkg::WBankCapacity-1:0] o_wresp_release_en,
  output logic [delay_calc_pkg::RBankCapacity-1:0] o_rdata_release_en,
  input  logic [delay_calc_pkg::WBankCapacity-1:0] i_wresp_released_onehot,
  input  logic [delay_calc_pkg::RBankCapacity-1:0] i_rdata_released_onehot
);
  import delay_calc_pkg::*;

  beat_cand_t w_cand;
  beat_cand_t r_cand;
  row_state_t row_state;
  logic w_issue;
  logic r_issue;
  logic done;

  write_slot_table #(
    .NumWSlots(NumWSlots)
  ) i_write_slot_table (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .i_waddr          (i_waddr),
    .i_waddr_valid    (i_waddr_valid),
    .o_waddr_ready    (o_waddr_ready),
    .i_wdata_valid    (i_wdata_valid),
    .o_wdata_ready    (o_wdata_ready),
    .i_row_state      (row_state),
    .i_issue          (w_issue),
    .i_done           (done),
    .o_cand           (w_cand),
    .o_release_en     (o_wresp_release_en),
    .i_released_onehot(i_wresp_released_onehot)
  );

  read_slot_table #(
    .NumRSlots(NumRSlots)
  ) i_read_slot_table (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .i_raddr          (i_raddr),
    .i_raddr_valid    (i_raddr_valid),
    .o_raddr_ready    (o_raddr_ready),
    .i_row_state      (row_state),
    .i_issue          (r_issue),
    .i_done           (done),
    .o_cand           (r_cand),
    .o_release_en     (o_rdata_release_en),
    .i_released_onehot(i_rdata_released_onehot)
  );

  rank_scheduler #(
    .RowHitCost    (RowHitCost),
    .ActivationCost(ActivationCost),
    .PrechargeCost (PrechargeCost)
  ) i_rank_scheduler (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .i_w_cand   (w_cand),
    .i_r_cand   (r_cand),
    .o_w_issue  (w_issue),
    .o_r_issue  (r_issue),
    .o_done     (done),
    .o_row_state(row_state)
  );

endmodule

/* tb/tb_clock_gen.sv */
// Testbench clock and reset
module tb_clock_gen #(
  parameter int unsigned ResetCycles = 5
) (
  output logic o_clk,
  output logic o_rst_n
);
  timeunit 1ns;
  timeprecision 1ps;

  // 20 ns period
  initial begin
    o_clk = 1'b0;
    forever #10 o_clk = ~o_clk;
  end

  initial begin
    o_rst_n = 1'b0;
    repeat (ResetCycles) @(posedge o_clk);
    @(negedge o_clk);
    o_rst_n = 1'b1;
  end

endmodule

/* tb/delay_calculator_tb.sv */
// Delay calculator testbench
module delay_calculator_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import delay_calc_pkg::*;

  localparam int unsigned NumSlots = 6;
  localparam int unsigned HitCycles = 4;
  localparam int unsigned ActCycles = 6;
  localparam int unsigned PreCycles = 5;

  logic clk;
  logic rst_n;
  wburst_req_t waddr;
  logic waddr_valid;
  logic waddr_ready;
  logic wdata_valid;
  logic wdata_ready;
  burst_req_t raddr;
  logic raddr_valid;
  logic raddr_ready;
  logic [WBankCapacity-1:0] wrel;
  logic [WBankCapacity-1:0] wfb;
  logic [RBankCapacity-1:0] rrel;
  logic [RBankCapacity-1:0] rfb;

  // Golden file columns
  string t_name[$];
  string t_kind[$];
  int t_iid[$];
  int t_addr[$];
  int t_len[$];
  int t_size[$];
  int t_dcnt[$];
  int t_gap[$];
  int t_exp[$];

  int cycle = 0;
  int limit = 0;
  integer seed = 32'h9bdad9a2;
  logic model_open = 1'b0;
  logic [RowWidth-1:0] model_row = '0;

  tb_clock_gen i_clk_gen (
    .o_clk  (clk),
    .o_rst_n(rst_n)
  );

  delay_calculator_top #(
    .NumWSlots     (NumSlots),
    .NumRSlots     (NumSlots),
    .RowHitCost    (HitCycles),
    .ActivationCost(ActCycles),
    .PrechargeCost (PreCycles)
  ) i_dut (
    .clk_i                  (clk),
    .rst_ni                 (rst_n),
    .i_waddr                (waddr),
    .i_waddr_valid          (waddr_valid),
    .o_waddr_ready          (waddr_ready),
    .i_wdata_valid          (wdata_valid),
    .o_wdata_ready          (wdata_ready),
    .i_raddr                (raddr),
    .i_raddr_valid          (raddr_valid),
    .o_raddr_ready          (raddr_ready),
    .o_wresp_release_en     (wrel),
    .o_rdata_release_en     (rrel),
    .i_wresp_released_onehot(wfb),
    .i_rdata_released_onehot(rfb)
  );

  task automatic stop_run();
    $display("SIMULATION FAILED");
    $fatal(1, "stopped at first error");
  endtask

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (limit > 0 && cycle >= limit) begin
      $display("Error: run exceeded %0d cycles without finishing", limit);
      stop_run();
    end
  end

  task automatic check_release_vec(input string name, input logic [WBankCapacity-1:0] exp_vec,
                                   input logic [WBankCapacity-1:0] act_vec);
    if (exp_vec !== act_vec) begin
      $display("Fail %s: expected %h actual %h", name, exp_vec, act_vec);
      stop_run();
    end
  endtask

  task automatic check_ready(input string name, input logic exp_rdy, input logic act_rdy);
    if (exp_rdy !== act_rdy) begin
      $display("Fail %s: expected %b actual %b", name, exp_rdy, act_rdy);
      stop_run();
    end
  endtask

  task automatic check_latency(input string name, input logic [DelayWidth-1:0] exp_lat,
                               input logic [DelayWidth-1:0] act_lat, input bit at_least);
    if (at_least ? (act_lat < exp_lat) : (act_lat !== exp_lat)) begin
      $display("Fail %s: expected %s%0d actual %0d", name, at_least ? ">=" : "", exp_lat,
               act_lat);
      stop_run();
    end
  endtask

  task automatic check_cost(input string name, input mem_cost_e exp_cost,
                            input mem_cost_e act_cost);
    if (exp_cost !== act_cost) begin
      $display("Fail %s: expected %s actual %s", name, exp_cost.name(), act_cost.name());
      stop_run();
    end
  endtask

  // Row buffer model kept by the testbench
  function automatic mem_cost_e expected_class(logic [AddrWidth-1:0] addr);
    if (!model_open) begin
      return COST_ACTIVATE;
    end
    return (addr[AddrWidth-1:RowOffsetWidth] == model_row) ? COST_HIT : COST_PRECHARGE;
  endfunction

  task automatic send_addr(input bit is_wr, input bit is_rd, input wburst_req_t w,
                           input burst_req_t r, output int acc);
    waddr = w;
    raddr = r;
    waddr_valid = is_wr;
    raddr_valid = is_rd;
    while ((is_wr && !waddr_ready) || (is_rd && !raddr_ready)) begin
      @(negedge clk);
    end
    acc = cycle + 1;
    @(negedge clk);
    waddr_valid = 1'b0;
    raddr_valid = 1'b0;
  endtask

  task automatic send_data(input int beats, input int max_gap, output int last_acc);
    int gap;
    last_acc = 0;
    for (int i = 0; i < beats; i++) begin
      gap = $unsigned($random(seed)) % (max_gap + 1);
      repeat (gap) @(negedge clk);
      wdata_valid = 1'b1;
      while (!wdata_ready) begin
        @(negedge clk);
      end
      last_acc = cycle + 1;
      @(negedge clk);
      wdata_valid = 1'b0;
    end
  endtask

  // Waits for a release, checks that it holds, then answers with feedback
  task automatic wait_release(input string name, input bit is_wr, input int iid,
                              output int rel);
    logic [WBankCapacity-1:0] mask;
    mask = WBankCapacity'(1) << iid;
    while (((is_wr ? wrel : rrel) & mask) == '0) begin
      @(negedge clk);
    end
    rel = cycle;
    repeat (2) begin
      @(negedge clk);
      if (((is_wr ? wrel : rrel) & mask) == '0) begin
        $display("Error: %s release bit dropped before its feedback", name);
        stop_run();
      end
    end
    if (is_wr) wfb = mask;
    else rfb = mask;
    @(negedge clk);
    wfb = '0;
    rfb = '0;
    check_release_vec({name, "_clear"}, '0, (is_wr ? wrel : rrel) & mask);
  endtask

  task automatic run_test(input int i);
    wburst_req_t w;
    burst_req_t r;
    int acc;
    int first_acc;
    int rel;
    int last;
    int extra;
    bit is_wr;
    mem_cost_e exp_cost;
    mem_cost_e act_cost;
    r = '{iid: WIidWidth'(t_iid[i]), addr: AddrWidth'(t_addr[i]),
          burst_len: BurstLenWidth'(t_len[i]), burst_size: BurstSizeWidth'(t_size[i])};
    w = '{req: r, data_cnt: BurstLenWidth'(t_dcnt[i])};
    exp_cost = expected_class(AddrWidth'(t_addr[i]));
    is_wr = t_kind[i] == "wr";
    if (t_kind[i] == "rd" || is_wr) begin
      send_addr(is_wr, !is_wr, w, r, acc);
      if (is_wr) begin
        // Data ready stays high only while the burst still lacks data
        check_ready({t_name[i], "_wdata_ready"}, t_dcnt[i] < t_len[i], wdata_ready);
      end
      if (is_wr && t_dcnt[i] < t_len[i]) begin
        // With late data the bound counts from the last data beat
        send_data(t_len[i] - t_dcnt[i], t_gap[i], last);
        check_ready({t_name[i], "_wdata_full"}, 1'b0, wdata_ready);
        wait_release(t_name[i], 1'b1, t_iid[i], rel);
        check_latency(t_name[i], DelayWidth'(t_exp[i]), DelayWidth'(rel - last), 1'b1);
      end else begin
        wait_release(t_name[i], is_wr, t_iid[i], rel);
        check_latency(t_name[i], DelayWidth'(t_exp[i]), DelayWidth'(rel - acc), 1'b0);
        extra = rel - acc - 2 - t_len[i] * HitCycles;
        if (extra == 0) act_cost = COST_HIT;
        else if (extra == ActCycles) act_cost = COST_ACTIVATE;
        else if (extra == ActCycles + PreCycles) act_cost = COST_PRECHARGE;
        else begin
          $display("Error: %s latency %0d fits no cost class", t_name[i], rel - acc);
          stop_run();
        end
        check_cost(t_name[i], exp_cost, act_cost);
      end
    end else if (t_kind[i] == "mix") begin
      send_addr(1'b1, 1'b1, w, r, acc);
      while ((wrel | rrel) == '0) begin
        @(negedge clk);
      end
      check_release_vec({t_name[i], "_first_w"}, WBankCapacity'(1) << t_iid[i], wrel);
      check_release_vec({t_name[i], "_first_r"}, '0, rrel);
      wait_release(t_name[i], 1'b1, t_iid[i], rel);
      check_latency(t_name[i], DelayWidth'(t_exp[i]), DelayWidth'(rel - acc), 1'b0);
      wait_release(t_name[i], 1'b0, t_iid[i], rel);
    end else begin
      first_acc = 0;
      for (int k = 0; k < NumSlots; k++) begin
        r.iid = WIidWidth'(t_iid[i] + k);
        send_addr(1'b0, 1'b1, w, r, acc);
        if (k == 0) first_acc = acc;
      end
      check_ready({t_name[i], "_raddr_full"}, 1'b0, raddr_ready);
      check_release_vec({t_name[i], "_early"}, '0, rrel);
      for (int k = 0; k < NumSlots; k++) begin
        wait_release(t_name[i], 1'b0, t_iid[i] + k, rel);
      end
      check_latency(t_name[i], DelayWidth'(t_exp[i]), DelayWidth'(rel - first_acc), 1'b0);
      repeat (10) @(negedge clk);
      check_release_vec({t_name[i], "_once"}, '0, rrel);
    end
    model_open = 1'b1;
    model_row = RowWidth'(t_addr[i] >> RowOffsetWidth);
    repeat (2) @(negedge clk);
  endtask

  initial begin
    int fd;
    int n;
    int sum;
    string line;
    string nm;
    string kd;
    int iid;
    int ad;
    int ln;
    int sz;
    int dc;
    int gp;
    int ex;
    waddr = '0;
    waddr_valid = 1'b0;
    wdata_valid = 1'b0;
    raddr = '0;
    raddr_valid = 1'b0;
    wfb = '0;
    rfb = '0;
    sum = 0;
    fd = $fopen("tb/golden_bursts.txt", "r");
    if (fd == 0) begin
      $display("Error: cannot open the golden burst file");
      stop_run();
    end
    while (!$feof(fd)) begin
      n = $fgets(line, fd);
      if (n > 1 && line[0] != "#") begin
        n = $sscanf(line, "%s %s %d %h %d %d %d %d %d", nm, kd, iid, ad, ln, sz, dc, gp, ex);
        if (n == 9) begin
          t_name.push_back(nm);
          t_kind.push_back(kd);
          t_iid.push_back(iid);
          t_addr.push_back(ad);
          t_len.push_back(ln);
          t_size.push_back(sz);
          t_dcnt.push_back(dc);
          t_gap.push_back(gp);
          t_exp.push_back(ex);
          sum += ex;
        end
      end
    end
    $fclose(fd);
    if (t_name.size() == 0) begin
      $display("Error: golden burst file holds no tests");
      stop_run();
    end
    limit = sum + 200;
    wait (rst_n === 1'b1);
    @(negedge clk);
    check_release_vec("reset_w", '0, wrel);
    check_release_vec("reset_r", '0, rrel);
    check_ready("reset_waddr_ready", 1'b1, waddr_ready);
    check_ready("reset_raddr_ready", 1'b1, raddr_ready);
    for (int i = 0; i < t_name.size(); i++) begin
      run_test(i);
    end
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

/* flist.f */
source/delay_calc_pkg.sv
source/write_slot_table.sv
source/read_slot_table.sv
source/rank_scheduler.sv
source/delay_calculator_top.sv
tb/tb_clock_gen.sv
tb/delay_calculator_tb.sv

/* Makefile */
# Verilator build for the delay calculator testbench

TOOL  = verilator
FLAGS = --binary --timing --assert -j 0 -Wno-fatal
TOP   = delay_calculator_tb
FLIST = flist.f
BUILD = obj_dir

.PHONY: compile run clean

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FLIST)

# The simulator exits with a failing status on any $$fatal
run: compile
	./$(BUILD)/V$(TOP)

clean:
	rm -rf $(BUILD)

/* tb/golden_bursts.txt */
# name kind iid addr_hex len size data_cnt max_data_gap expected
# expected is release latency, or its lower bound after the last late data beat
rd_closed rd 1 00400 4 2 0 0 24
rd_open_hit rd 2 00480 4 2 0 0 18
rd_conflict rd 3 00c00 4 2 0 0 29
wr_imm_hit wr 4 00c40 4 2 4 0 18
wr_late_hit wr 5 00c80 4 2 1 5 6
mix_same_row mix 6 00d00 2 2 2 0 10
rd_fill fill 0 00d40 2 2 0 0 50
rd_conflict_r5 rd 7 01400 8 0 0 0 45
wr_imm_conflict wr 1 00800 2 3 2 0 21
rd_hit_r2 rd 4 00810 1 2 0 0 6
wr_late_all wr 2 00820 3 2 0 3 6
mix_single mix 7 00900 1 2 1 0 6
